//--- design/axi_bus_master.sv
`timescale 1ns/100ps
`default_nettype none

module axi_bus_master (
    input  logic                    clk,
    input  logic                    reset_i,
    // Fetch client
    input  mem_bus_pkg::fetch_req_t fetch_req_i,
    output logic                    fetch_rdy_o,
    output mem_bus_pkg::ret_t       fetch_ret_o,
    // Data client
    input  mem_bus_pkg::data_req_t  data_req_i,
    output logic                    data_rdy_o,
    output mem_bus_pkg::ret_t       data_ret_o,
    output logic                    data_wr_done_o,
    // AXI master side
    output mem_bus_pkg::axi_ar_t    ar_o,
    input  logic                    arready_i,
    input  mem_bus_pkg::axi_r_t     r_i,
    output mem_bus_pkg::axi_aw_t    aw_o,
    input  logic                    awready_i,
    output mem_bus_pkg::axi_w_t     w_o,
    input  logic                    wready_i,
    input  mem_bus_pkg::axi_b_t     b_i
);

    // Ports to arbiter
    mem_bus_pkg::rd_req_t fetch_rd;
    mem_bus_pkg::rd_req_t data_rd;
    logic                 fetch_grant;
    logic                 data_grant;
    mem_bus_pkg::axi_r_t  fetch_r;  // Valid only for FETCH_ID beats
    mem_bus_pkg::axi_r_t  data_r;   // Valid only for DATA_ID beats

    fetch_read_port u_fetch_port (
        .clk     (clk),
        .reset_i (reset_i),
        .req_i   (fetch_req_i),
        .grant_i (fetch_grant),
        .r_i     (fetch_r),
        .rdy_o   (fetch_rdy_o),
        .rd_req_o(fetch_rd),
        .ret_o   (fetch_ret_o)
    );

    data_access_port u_data_port (
        .clk      (clk),
        .reset_i  (reset_i),
        .req_i    (data_req_i),
        .grant_i  (data_grant),
        .r_i      (data_r),
        .awready_i(awready_i),
        .wready_i (wready_i),
        .b_i      (b_i),
        .rdy_o    (data_rdy_o),
        .rd_req_o (data_rd),
        .ret_o    (data_ret_o),
        .aw_o     (aw_o),
        .w_o      (w_o),
        .wr_done_o(data_wr_done_o)
    );

    // Writes bypass this, only the data port writes
    axi_read_arbiter u_rd_arb (
        .clk          (clk),
        .reset_i      (reset_i),
        .fetch_rd_i   (fetch_rd),
        .data_rd_i    (data_rd),
        .arready_i    (arready_i),
        .r_i          (r_i),
        .fetch_grant_o(fetch_grant),
        .data_grant_o (data_grant),
        .ar_o         (ar_o),
        .fetch_r_o    (fetch_r),
        .data_r_o     (data_r)
    );

endmodule

`default_nettype wire

//--- design/axi_read_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module axi_read_arbiter (
    input  logic                 clk,
    input  logic                 reset_i,
    input  mem_bus_pkg::rd_req_t fetch_rd_i,
    input  mem_bus_pkg::rd_req_t data_rd_i,
    input  logic                 arready_i,
    input  mem_bus_pkg::axi_r_t  r_i,
    output logic                 fetch_grant_o,
    output logic                 data_grant_o,
    output mem_bus_pkg::axi_ar_t ar_o,
    output mem_bus_pkg::axi_r_t  fetch_r_o,
    output mem_bus_pkg::axi_r_t  data_r_o
);

    logic                 prefer_data;  // Round robin pointer
    logic                 locked;       // AR is stalled, choice is frozen
    logic                 locked_data;
    logic                 pick_data;
    logic                 sel_data;
    logic                 ar_hs;
    mem_bus_pkg::rd_req_t sel_req;

    ////////////////////////////////////////////////////////////////////////////
    // Selection
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        if (fetch_rd_i.valid && data_rd_i.valid) begin
            pick_data = prefer_data;
        end else begin
            pick_data = data_rd_i.valid;
        end
    end

    assign sel_data = locked ? locked_data : pick_data;
    assign sel_req  = sel_data ? data_rd_i : fetch_rd_i;

    assign ar_o.valid = sel_req.valid;
    assign ar_o.id    = sel_req.id;
    assign ar_o.addr  = sel_req.addr;
    assign ar_o.size  = sel_req.size;

    assign ar_hs         = ar_o.valid && arready_i;
    assign fetch_grant_o = ar_hs && !sel_data;
    assign data_grant_o  = ar_hs && sel_data;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            prefer_data <= 1'b0;  // Fetch first out of reset
            locked      <= 1'b0;
            locked_data <= 1'b0;
        end else begin
            if (ar_hs) begin
                prefer_data <= !sel_data;  // Loser goes next
                locked      <= 1'b0;
            end else if (ar_o.valid) begin
                locked      <= 1'b1;
                locked_data <= sel_data;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // R routing by ID
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        fetch_r_o       = r_i;
        data_r_o        = r_i;
        fetch_r_o.valid = r_i.valid && (r_i.id == mem_bus_pkg::FETCH_ID);
        data_r_o.valid  = r_i.valid && (r_i.id == mem_bus_pkg::DATA_ID);
    end

    // Locked choice keeps AR steady across a stall
    a_ar_hold: assert property (@(posedge clk) disable iff (reset_i)
        ar_o.valid && !arready_i |=> ar_o.valid && $stable(ar_o.addr)
            && $stable(ar_o.id));

endmodule

`default_nettype wire

//--- design/data_access_port.sv
`timescale 1ns/100ps
`default_nettype none

module data_access_port (
    input  logic                   clk,
    input  logic                   reset_i,
    input  mem_bus_pkg::data_req_t req_i,
    input  logic                   grant_i,
    input  mem_bus_pkg::axi_r_t    r_i,
    input  logic                   awready_i,
    input  logic                   wready_i,
    input  mem_bus_pkg::axi_b_t    b_i,
    output logic                   rdy_o,
    output mem_bus_pkg::rd_req_t   rd_req_o,
    output mem_bus_pkg::ret_t      ret_o,
    output mem_bus_pkg::axi_aw_t   aw_o,
    output mem_bus_pkg::axi_w_t    w_o,
    output logic                   wr_done_o
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_RD_ADDR,
        ST_RD_DATA,
        ST_WR,       // AW and W outstanding
        ST_WR_RESP   // Both sent, waiting for B
    } state_t;

    state_t                         state;
    logic [mem_bus_pkg::ADDR_W-1:0] addr_q;
    logic [mem_bus_pkg::SIZE_W-1:0] size_q;
    logic [mem_bus_pkg::STRB_W-1:0] strb_q;
    logic [mem_bus_pkg::DATA_W-1:0] wdata_q;
    logic [mem_bus_pkg::DATA_W-1:0] ret_data_q;
    logic                           ret_valid_q;
    logic                           wr_done_q;
    logic                           aw_done;
    logic                           w_done;
    logic                           aw_hs;
    logic                           w_hs;
    logic                           b_hit;

    assign aw_hs = aw_o.valid && awready_i;
    assign w_hs  = w_o.valid && wready_i;
    assign b_hit = b_i.valid && (b_i.id == mem_bus_pkg::DATA_ID);

    ////////////////////////////////////////////////////////////////////////////
    // Control
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset_i) begin
            state       <= ST_IDLE;
            aw_done     <= 1'b0;
            w_done      <= 1'b0;
            ret_valid_q <= 1'b0;
            wr_done_q   <= 1'b0;
        end else begin
            ret_valid_q <= (state == ST_RD_DATA) && r_i.valid;
            wr_done_q   <= (state == ST_WR_RESP) && b_hit;
            case (state)
                ST_IDLE: begin
                    if (req_i.valid) begin
                        state <= req_i.write ? ST_WR : ST_RD_ADDR;
                    end
                end
                ST_RD_ADDR: begin
                    if (grant_i) begin
                        state <= ST_RD_DATA;
                    end
                end
                ST_RD_DATA: begin
                    if (r_i.valid) begin
                        state <= ST_IDLE;
                    end
                end
                ST_WR: begin
                    // AW and W finish in any order
                    if ((aw_done || aw_hs) && (w_done || w_hs)) begin
                        state <= ST_WR_RESP;
                    end
                end
                ST_WR_RESP: begin
                    if (b_hit) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
            if (state == ST_WR) begin
                aw_done <= aw_done || aw_hs;
                w_done  <= w_done || w_hs;
            end else begin
                aw_done <= 1'b0;
                w_done  <= 1'b0;
            end
        end
    end

    // Request and read data capture
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && req_i.valid) begin
            addr_q  <= req_i.addr;
            size_q  <= req_i.size;
            strb_q  <= req_i.strb;
            wdata_q <= req_i.data;
        end
        if (state == ST_RD_DATA && r_i.valid) begin
            ret_data_q <= r_i.data;
        end
    end

    assign rdy_o          = (state == ST_IDLE);
    assign rd_req_o.valid = (state == ST_RD_ADDR);
    assign rd_req_o.id    = mem_bus_pkg::DATA_ID;
    assign rd_req_o.addr  = addr_q;
    assign rd_req_o.size  = size_q;
    assign ret_o.valid    = ret_valid_q;
    assign ret_o.data     = ret_data_q;
    assign wr_done_o      = wr_done_q;

    assign aw_o.valid = (state == ST_WR) && !aw_done;
    assign aw_o.id    = mem_bus_pkg::DATA_ID;
    assign aw_o.addr  = addr_q;
    assign aw_o.size  = size_q;
    assign w_o.valid  = (state == ST_WR) && !w_done;
    assign w_o.data   = wdata_q;
    assign w_o.strb   = strb_q;
    assign w_o.last   = 1'b1;  // Single beat

    a_aw_hold: assert property (@(posedge clk) disable iff (reset_i)
        aw_o.valid && !awready_i |=> aw_o.valid && $stable(aw_o));
    a_w_hold: assert property (@(posedge clk) disable iff (reset_i)
        w_o.valid && !wready_i |=> w_o.valid && $stable(w_o));

endmodule

`default_nettype wire

//--- design/fetch_read_port.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_read_port (
    input  logic                    clk,
    input  logic                    reset_i,
    input  mem_bus_pkg::fetch_req_t req_i,
    input  logic                    grant_i,
    input  mem_bus_pkg::axi_r_t     r_i,
    output logic                    rdy_o,
    output mem_bus_pkg::rd_req_t    rd_req_o,
    output mem_bus_pkg::ret_t       ret_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR,  // Waiting for the arbiter
        ST_DATA   // AR sent, waiting for R
    } state_t;

    state_t                         state;
    logic [mem_bus_pkg::ADDR_W-1:0] addr_q;
    logic                           ret_valid_q;
    logic [mem_bus_pkg::DATA_W-1:0] ret_data_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (req_i.valid) begin
                        state <= ST_ADDR;
                    end
                end
                ST_ADDR: begin
                    if (grant_i) begin
                        state <= ST_DATA;
                    end
                end
                ST_DATA: begin
                    if (r_i.valid) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Return pulse lines up with rdy_o coming back
    always_ff @(posedge clk) begin
        if (reset_i) begin
            ret_valid_q <= 1'b0;
        end else begin
            ret_valid_q <= (state == ST_DATA) && r_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && req_i.valid) begin
            addr_q <= req_i.addr;
        end
        if (state == ST_DATA && r_i.valid) begin
            ret_data_q <= r_i.data;
        end
    end

    assign rdy_o          = (state == ST_IDLE);
    assign rd_req_o.valid = (state == ST_ADDR);
    assign rd_req_o.id    = mem_bus_pkg::FETCH_ID;
    assign rd_req_o.addr  = addr_q;
    assign rd_req_o.size  = mem_bus_pkg::SIZE_WORD;  // Fetch is always a word
    assign ret_o.valid    = ret_valid_q;
    assign ret_o.data     = ret_data_q;

    // Arbiter must only grant a pending request
    a_grant_when_pending: assert property (@(posedge clk) disable iff (reset_i)
        grant_i |-> state == ST_ADDR);

endmodule

`default_nettype wire

//--- design/mem_bus_pkg.sv
`default_nettype none

package mem_bus_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Bus widths and fixed IDs
    ////////////////////////////////////////////////////////////////////////////
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;
    localparam int ID_W   = 4;
    localparam int SIZE_W = 3;

    localparam logic [ID_W-1:0]   FETCH_ID  = 4'd0;  // Instruction reads
    localparam logic [ID_W-1:0]   DATA_ID   = 4'd1;  // Loads and stores
    localparam logic [SIZE_W-1:0] SIZE_WORD = 3'd2;  // 4 bytes per beat

    ////////////////////////////////////////////////////////////////////////////
    // Client side
    ////////////////////////////////////////////////////////////////////////////
    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr;
    } fetch_req_t;

    typedef struct packed {
        logic              valid;
        logic              write;  // 1 = store
        logic [ADDR_W-1:0] addr;
        logic [SIZE_W-1:0] size;
        logic [STRB_W-1:0] strb;
        logic [DATA_W-1:0] data;
    } data_req_t;

    // Read return, one cycle pulse
    typedef struct packed {
        logic              valid;
        logic [DATA_W-1:0] data;
    } ret_t;

    // Port toward the read arbiter
    typedef struct packed {
        logic              valid;
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        logic [SIZE_W-1:0] size;
    } rd_req_t;

    ////////////////////////////////////////////////////////////////////////////
    // AXI channels, single beat only
    ////////////////////////////////////////////////////////////////////////////
    typedef struct packed {
        logic              valid;
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        logic [SIZE_W-1:0] size;
    } axi_ar_t;

    typedef struct packed {
        logic              valid;
        logic [ID_W-1:0]   id;
        logic [DATA_W-1:0] data;
        logic [1:0]        resp;
        logic              last;
    } axi_r_t;

    typedef struct packed {
        logic              valid;
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        logic [SIZE_W-1:0] size;
    } axi_aw_t;

    typedef struct packed {
        logic              valid;
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
        logic              last;
    } axi_w_t;

    typedef struct packed {
        logic            valid;
        logic [ID_W-1:0] id;
        logic [1:0]      resp;
    } axi_b_t;

endpackage

`default_nettype wire

//--- dv/axi_mem_model.sv
`timescale 1ns/100ps
`default_nettype none

module axi_mem_model (
    input  logic                 clk,
    input  logic                 reset_i,
    input  mem_bus_pkg::axi_ar_t ar_i,
    output logic                 arready_o,
    output mem_bus_pkg::axi_r_t  r_o,
    input  mem_bus_pkg::axi_aw_t aw_i,
    output logic                 awready_o,
    input  mem_bus_pkg::axi_w_t  w_i,
    output logic                 wready_o,
    output mem_bus_pkg::axi_b_t  b_o
);

    logic [mem_bus_pkg::DATA_W-1:0] mem [256];  // Word index is addr[9:2]

    // One read slot per ID, each port keeps a single read in flight
    logic                           rd_busy [2];
    logic [mem_bus_pkg::ID_W-1:0]   rd_id   [2];
    logic [mem_bus_pkg::ADDR_W-1:0] rd_addr [2];
    logic [3:0]                     rd_wait [2];

    logic                           aw_got;
    logic                           w_got;
    logic [mem_bus_pkg::ID_W-1:0]   wr_id;
    logic [mem_bus_pkg::ADDR_W-1:0] wr_addr;
    logic [mem_bus_pkg::DATA_W-1:0] wr_data;
    logic [mem_bus_pkg::STRB_W-1:0] wr_strb;
    logic                           b_busy;
    logic [3:0]                     b_wait;

    logic [31:0] rnd;
    logic        rdy0;
    logic        rdy1;
    logic        sel;

    always @(posedge clk) begin
        rnd = $urandom;
        if (reset_i) begin
            arready_o  <= 1'b0;
            awready_o  <= 1'b0;
            wready_o   <= 1'b0;
            r_o        <= '0;
            b_o        <= '0;
            rd_busy[0] <= 1'b0;
            rd_busy[1] <= 1'b0;
            aw_got     <= 1'b0;
            w_got      <= 1'b0;
            b_busy     <= 1'b0;
            for (int i = 0; i < 256; i++) begin
                mem[i] <= $urandom;
            end
        end else begin
            // Each ready is high about three cycles out of four
            arready_o <= rnd[0] | rnd[1];
            awready_o <= rnd[2] | rnd[3];
            wready_o  <= rnd[4] | rnd[5];

            ////////////////////////////////////////////////////////////////////////////
            // Read side
            ////////////////////////////////////////////////////////////////////////////
            rdy0 = rd_busy[0] && (rd_wait[0] == 4'd0);
            rdy1 = rd_busy[1] && (rd_wait[1] == 4'd0);
            for (int s = 0; s < 2; s++) begin
                if (rd_busy[s] && rd_wait[s] != 4'd0) begin
                    rd_wait[s] <= rd_wait[s] - 4'd1;
                end
            end
            r_o.valid <= 1'b0;
            if (rdy0 || rdy1) begin
                sel = rdy1 && (!rdy0 || rnd[16]);  // Either ID may go first
                r_o.valid    <= 1'b1;
                r_o.id       <= rd_id[sel];
                r_o.data     <= mem[rd_addr[sel][9:2]];
                r_o.resp     <= 2'b00;
                r_o.last     <= 1'b1;
                rd_busy[sel] <= 1'b0;
            end
            if (ar_i.valid && arready_o) begin
                rd_busy[ar_i.id[0]] <= 1'b1;
                rd_id[ar_i.id[0]]   <= ar_i.id;
                rd_addr[ar_i.id[0]] <= ar_i.addr;
                rd_wait[ar_i.id[0]] <= rnd[11:8];
            end

            ////////////////////////////////////////////////////////////////////////////
            // Write side
            ////////////////////////////////////////////////////////////////////////////
            if (aw_i.valid && awready_o) begin
                aw_got  <= 1'b1;
                wr_id   <= aw_i.id;
                wr_addr <= aw_i.addr;
            end
            if (w_i.valid && wready_o) begin
                w_got   <= 1'b1;
                wr_data <= w_i.data;
                wr_strb <= w_i.strb;
            end
            if (aw_got && w_got) begin
                for (int b = 0; b < mem_bus_pkg::STRB_W; b++) begin
                    if (wr_strb[b]) begin
                        mem[wr_addr[9:2]][8*b +: 8] <= wr_data[8*b +: 8];
                    end
                end
                aw_got <= 1'b0;
                w_got  <= 1'b0;
                b_busy <= 1'b1;
                b_wait <= rnd[15:12];
            end
            b_o.valid <= 1'b0;
            if (b_busy) begin
                if (b_wait == 4'd0) begin
                    b_o.valid <= 1'b1;
                    b_o.id    <= wr_id;
                    b_o.resp  <= 2'b00;
                    b_busy    <= 1'b0;
                end else begin
                    b_wait <= b_wait - 4'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- dv/tb_axi_bus_master.sv
`timescale 1ns/100ps
`default_nettype none

module tb_axi_bus_master;

    localparam int NUM_TRANS = 2000;  // Per port
    localparam int TIMEOUT   = 200;   // Cycles per wait

    logic clk = 1'b0;
    logic reset_i;

    mem_bus_pkg::fetch_req_t fetch_req_i;
    mem_bus_pkg::data_req_t  data_req_i;
    logic                    fetch_rdy_o;
    logic                    data_rdy_o;
    mem_bus_pkg::ret_t       fetch_ret_o;
    mem_bus_pkg::ret_t       data_ret_o;
    logic                    data_wr_done_o;
    mem_bus_pkg::axi_ar_t    ar_o;
    mem_bus_pkg::axi_aw_t    aw_o;
    mem_bus_pkg::axi_w_t     w_o;
    logic                    arready_i;
    logic                    awready_i;
    logic                    wready_i;
    mem_bus_pkg::axi_r_t     r_i;
    mem_bus_pkg::axi_b_t     b_i;

    logic [31:0] ref_mem [256];  // Reference copy of the slave memory

    // Current request of each client for the AR monitor
    logic [31:0] fetch_addr_cur;
    logic [31:0] data_addr_cur;
    logic [2:0]  data_size_cur;

    logic                 ar_hold;
    logic                 aw_hold;
    logic                 w_hold;
    mem_bus_pkg::axi_ar_t ar_prev;
    mem_bus_pkg::axi_aw_t aw_prev;
    mem_bus_pkg::axi_w_t  w_prev;
    int                   fetch_skip;  // AR handshakes lost while pending
    int                   data_skip;

    always #2 clk = ~clk;

    axi_bus_master dut (
        .clk           (clk),
        .reset_i       (reset_i),
        .fetch_req_i   (fetch_req_i),
        .fetch_rdy_o   (fetch_rdy_o),
        .fetch_ret_o   (fetch_ret_o),
        .data_req_i    (data_req_i),
        .data_rdy_o    (data_rdy_o),
        .data_ret_o    (data_ret_o),
        .data_wr_done_o(data_wr_done_o),
        .ar_o          (ar_o),
        .arready_i     (arready_i),
        .r_i           (r_i),
        .aw_o          (aw_o),
        .awready_i     (awready_i),
        .w_o           (w_o),
        .wready_i      (wready_i),
        .b_i           (b_i)
    );

    axi_mem_model u_mem (
        .clk      (clk),
        .reset_i  (reset_i),
        .ar_i     (ar_o),
        .arready_o(arready_i),
        .r_o      (r_i),
        .aw_i     (aw_o),
        .awready_o(awready_i),
        .w_i      (w_o),
        .wready_o (wready_i),
        .b_o      (b_i)
    );

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic abort_run(input string what);
        $display("Run stopped: %s at %0t ns", what, $time);
        $display("*** FAILED ***");
        $fatal(1, "%s", what);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Client transactions
    ////////////////////////////////////////////////////////////////////////////
    task automatic fetch_read(input logic [31:0] addr);
        int n;
        n = 0;
        while (!fetch_rdy_o) begin
            @(posedge clk);
            n++;
            if (n > TIMEOUT) begin
                abort_run("fetch_rdy_o stayed low");
            end
        end
        fetch_addr_cur = addr;
        fetch_req_i.addr  <= addr;
        fetch_req_i.valid <= 1'b1;
        @(posedge clk);  // Accepted on this edge
        fetch_req_i.valid <= 1'b0;
        check_value("fetch_ret_o.valid", 64'(fetch_ret_o.valid), 64'(0));
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > TIMEOUT) begin
                abort_run("no fetch return");
            end
            if (!fetch_ret_o.valid) begin
                check_value("fetch_rdy_o", 64'(fetch_rdy_o), 64'(0));
            end
        end while (!fetch_ret_o.valid);
        check_value("fetch_rdy_o", 64'(fetch_rdy_o), 64'(1));  // Ready again with the return
        check_value("fetch_ret_o.data", 64'(fetch_ret_o.data), 64'(ref_mem[addr[9:2]]));
    endtask

    task automatic data_read(input logic [31:0] addr, input logic [2:0] size);
        int n;
        n = 0;
        while (!data_rdy_o) begin
            @(posedge clk);
            n++;
            if (n > TIMEOUT) begin
                abort_run("data_rdy_o stayed low before a read");
            end
        end
        data_addr_cur = addr;
        data_size_cur = size;
        data_req_i.write <= 1'b0;
        data_req_i.addr  <= addr;
        data_req_i.size  <= size;
        data_req_i.valid <= 1'b1;
        @(posedge clk);
        data_req_i.valid <= 1'b0;
        check_value("data_ret_o.valid", 64'(data_ret_o.valid), 64'(0));
        check_value("data_wr_done_o", 64'(data_wr_done_o), 64'(0));
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > TIMEOUT) begin
                abort_run("no data read return");
            end
            if (!data_ret_o.valid) begin
                check_value("data_rdy_o", 64'(data_rdy_o), 64'(0));
            end
        end while (!data_ret_o.valid);
        check_value("data_rdy_o", 64'(data_rdy_o), 64'(1));
        check_value("data_ret_o.data", 64'(data_ret_o.data), 64'(ref_mem[addr[9:2]]));
    endtask

    task automatic data_write(input logic [31:0] addr, input logic [3:0] strb,
                              input logic [31:0] wdata);
        int n;
        n = 0;
        while (!data_rdy_o) begin
            @(posedge clk);
            n++;
            if (n > TIMEOUT) begin
                abort_run("data_rdy_o stayed low before a write");
            end
        end
        data_req_i.write <= 1'b1;
        data_req_i.addr  <= addr;
        data_req_i.size  <= mem_bus_pkg::SIZE_WORD;
        data_req_i.strb  <= strb;
        data_req_i.data  <= wdata;
        data_req_i.valid <= 1'b1;
        @(posedge clk);
        data_req_i.valid <= 1'b0;
        check_value("data_wr_done_o", 64'(data_wr_done_o), 64'(0));
        check_value("data_ret_o.valid", 64'(data_ret_o.valid), 64'(0));
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > TIMEOUT) begin
                abort_run("no write response");
            end
            if (!data_wr_done_o) begin
                check_value("data_rdy_o", 64'(data_rdy_o), 64'(0));
            end
            if (aw_o.valid) begin
                check_value("aw_o.id", 64'(aw_o.id), 64'(mem_bus_pkg::DATA_ID));
                check_value("aw_o.addr", 64'(aw_o.addr), 64'(addr));
                check_value("aw_o.size", 64'(aw_o.size), 64'(mem_bus_pkg::SIZE_WORD));
            end
            if (w_o.valid) begin
                check_value("w_o.data", 64'(w_o.data), 64'(wdata));
                check_value("w_o.strb", 64'(w_o.strb), 64'(strb));
                check_value("w_o.last", 64'(w_o.last), 64'(1));
            end
        end while (!data_wr_done_o);
        check_value("data_rdy_o", 64'(data_rdy_o), 64'(1));
        // Merge the completed write by strobes
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                ref_mem[addr[9:2]][8*b +: 8] = wdata[8*b +: 8];
            end
        end
    endtask

    task automatic run_fetch_client;
        logic [31:0] rnd;
        for (int i = 0; i < NUM_TRANS; i++) begin
            rnd = $urandom;
            repeat (rnd[1:0]) @(posedge clk);
            fetch_read({rnd[31:10], 1'b0, rnd[8:2], 2'b00});  // Words 0 to 127
        end
    endtask

    task automatic run_data_client;
        logic [31:0] rnd;
        logic [31:0] addr;
        for (int i = 0; i < NUM_TRANS; i++) begin
            rnd  = $urandom;
            addr = {rnd[31:10], 1'b1, rnd[8:2], 2'b00};  // Words 128 to 255
            repeat (rnd[1:0]) @(posedge clk);
            if (rnd[9]) begin
                data_write(addr, 4'($urandom), $urandom);
            end else begin
                data_read(addr, 3'($urandom_range(2, 0)));
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Bus monitor
    ////////////////////////////////////////////////////////////////////////////
    always @(posedge clk) begin
        if (reset_i) begin
            ar_hold    <= 1'b0;
            aw_hold    <= 1'b0;
            w_hold     <= 1'b0;
            fetch_skip <= 0;
            data_skip  <= 0;
        end else begin
            // Stalled channels keep valid and payload
            if (ar_hold) begin
                check_value("ar_o under stall", 64'(ar_o), 64'(ar_prev));
            end
            if (aw_hold) begin
                check_value("aw_o under stall", 64'(aw_o), 64'(aw_prev));
            end
            if (w_hold) begin
                check_value("w_o under stall", 64'(w_o), 64'(w_prev));
            end
            ar_hold <= ar_o.valid && !arready_i;
            aw_hold <= aw_o.valid && !awready_i;
            w_hold  <= w_o.valid && !wready_i;
            ar_prev <= ar_o;
            aw_prev <= aw_o;
            w_prev  <= w_o;

            if (ar_o.valid && arready_i) begin
                if (ar_o.id == mem_bus_pkg::FETCH_ID) begin
                    check_value("ar_o.size", 64'(ar_o.size), 64'(mem_bus_pkg::SIZE_WORD));
                    check_value("ar_o.addr", 64'(ar_o.addr), 64'(fetch_addr_cur));
                end else begin
                    check_value("ar_o.id", 64'(ar_o.id), 64'(mem_bus_pkg::DATA_ID));
                    check_value("ar_o.addr", 64'(ar_o.addr), 64'(data_addr_cur));
                    check_value("ar_o.size", 64'(ar_o.size), 64'(data_size_cur));
                end
            end

            // Round robin fairness
            if (fetch_skip > 1) begin
                abort_run("fetch read not granted within two AR handshakes");
            end
            if (data_skip > 1) begin
                abort_run("data read not granted within two AR handshakes");
            end
            if (!dut.fetch_rd.valid) begin
                fetch_skip <= 0;
            end else if (ar_o.valid && arready_i && ar_o.id != mem_bus_pkg::FETCH_ID) begin
                fetch_skip <= fetch_skip + 1;
            end
            if (!dut.data_rd.valid) begin
                data_skip <= 0;
            end else if (ar_o.valid && arready_i && ar_o.id != mem_bus_pkg::DATA_ID) begin
                data_skip <= data_skip + 1;
            end
        end
    end

    initial begin
        reset_i        <= 1'b1;
        fetch_req_i    <= '0;
        data_req_i     <= '0;
        fetch_addr_cur = '0;
        data_addr_cur  = '0;
        data_size_cur  = '0;
        void'($urandom(32'h248c));

        repeat (16) @(posedge clk);
        reset_i <= 1'b0;
        @(posedge clk);
        check_value("fetch_rdy_o", 64'(fetch_rdy_o), 64'(1));
        check_value("data_rdy_o", 64'(data_rdy_o), 64'(1));
        check_value("ar_o.valid", 64'(ar_o.valid), 64'(0));
        check_value("aw_o.valid", 64'(aw_o.valid), 64'(0));
        check_value("w_o.valid", 64'(w_o.valid), 64'(0));
        check_value("fetch_ret_o.valid", 64'(fetch_ret_o.valid), 64'(0));
        check_value("data_ret_o.valid", 64'(data_ret_o.valid), 64'(0));
        check_value("data_wr_done_o", 64'(data_wr_done_o), 64'(0));
        for (int i = 0; i < 256; i++) begin
            ref_mem[i] = u_mem.mem[i];  // Same contents the slave starts with
        end

        fork
            run_fetch_client();
            run_data_client();
        join

        // No stray returns once traffic stops
        repeat (20) begin
            @(posedge clk);
            check_value("fetch_ret_o.valid", 64'(fetch_ret_o.valid), 64'(0));
            check_value("data_ret_o.valid", 64'(data_ret_o.valid), 64'(0));
            check_value("data_wr_done_o", 64'(data_wr_done_o), 64'(0));
        end
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_axi_bus_master -f sources.f -o sim_tb

output=$(./obj_dir/sim_tb 2>&1) || true
echo "$output"

if grep -qF "*** PASSED ***" <<< "$output"; then
    exit 0
fi
exit 1

//--- sources.f
design/mem_bus_pkg.sv
design/fetch_read_port.sv
design/data_access_port.sv
design/axi_read_arbiter.sv
design/axi_bus_master.sv
dv/axi_mem_model.sv
dv/tb_axi_bus_master.sv
